/* src/daf_consts.svh */
// shared timing and scaling constants for the daf effects chain, included by the RTL modules
`ifndef DAF_CONSTS_SVH
`define DAF_CONSTS_SVH

// clocks per stereo sample frame
`define DAF_SAMPLE_CYCLES 32

// comb filter delay in sample frames
`define DAF_COMB_DELAY 8

// fade gain value for unity, full scale of the fader
`define DAF_FADE_UNITY 16

// threshold increment per pot count
`define DAF_POT_STEP 2048

`endif

/* src/daf_pkg.sv */
// sample and mode types shared across the daf design and its testbench
`default_nettype none

package daf_pkg;

  // one signed audio channel
  typedef logic signed [15:0] sample_t;

  // stereo pair, left in the upper half to match temp_in/temp_out
  typedef struct packed {
    sample_t left;
    sample_t right;
  } stereo_t;

  // effect enables, bit 0 is the comb filter
  typedef struct packed {
    logic fade;
    logic comp;
    logic clip;
    logic comb;
  } mode_t;

endpackage

`default_nettype wire

/* src/effect_ctrl.sv */
// frame sequencer: counts clocks per sample, captures input and mode, fires the stage steps
`default_nettype none
`include "daf_consts.svh"

module effect_ctrl (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic [3:0]        swch_mode_en,
  input  daf_pkg::stereo_t  temp_in,
  input  daf_pkg::stereo_t  gain_out,
  output daf_pkg::mode_t    mode,
  output daf_pkg::stereo_t  in_sample,
  output logic              comb_step,
  output logic              dyn_step,
  output logic              gain_step,
  output logic              sample_strobe,
  output daf_pkg::stereo_t  temp_out
);
  import daf_pkg::*;

  localparam int CNT_W = $clog2(`DAF_SAMPLE_CYCLES);

  logic [CNT_W-1:0] frame_cnt;

  // clock position inside the current sample frame
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      frame_cnt <= '0;
    end else if (frame_cnt == CNT_W'(`DAF_SAMPLE_CYCLES - 1)) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 1'b1;
    end
  end

  // frame boundary and the three stage slots right after it
  assign sample_strobe = (frame_cnt == CNT_W'(0));
  assign comb_step     = (frame_cnt == CNT_W'(1));
  assign dyn_step      = (frame_cnt == CNT_W'(2));
  assign gain_step     = (frame_cnt == CNT_W'(3));

  // at the boundary the new sample comes in and last frame's result goes out
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      in_sample <= '0;
      mode      <= '0;
      temp_out  <= '0;
    end else if (sample_strobe) begin
      in_sample <= temp_in;
      mode      <= mode_t'(swch_mode_en);
      temp_out  <= gain_out;
    end
  end

endmodule

`default_nettype wire

/* src/comb_filter.sv */
// fixed-delay comb filter, averages each sample with the one from a set number of frames back
`default_nettype none
`include "daf_consts.svh"

module comb_filter (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic              comb_step,
  input  logic              mem_clr,
  input  logic              enable,
  input  daf_pkg::stereo_t  in_sample,
  output daf_pkg::stereo_t  comb_out
);
  import daf_pkg::*;

  localparam int DEPTH = `DAF_COMB_DELAY;
  localparam int PTR_W = $clog2(DEPTH);

  stereo_t          delay_mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  stereo_t          delayed;

  // mean of two channels, floored, through a 17-bit sum
  function automatic sample_t avg(sample_t a, sample_t b);
    logic signed [16:0] sum;
    sum = {a[15], a} + {b[15], b};
    return sum[16:1];
  endfunction

  // slot under the write pointer holds the oldest sample
  assign delayed = mem_clr ? '0 : delay_mem[wr_ptr];

  // history keeps filling while bypassed so enabling is seamless
  always_ff @(posedge tb_clk) begin
    if (!rst_n || mem_clr) begin
      for (int i = 0; i < DEPTH; i++) begin
        delay_mem[i] <= '0;
      end
      wr_ptr <= '0;
    end else if (comb_step) begin
      delay_mem[wr_ptr] <= in_sample;
      if (wr_ptr == PTR_W'(DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      comb_out <= '0;
    end else if (comb_step) begin
      if (enable) begin
        comb_out.left  <= avg(in_sample.left, delayed.left);
        comb_out.right <= avg(in_sample.right, delayed.right);
      end else begin
        comb_out <= in_sample;
      end
    end
  end

endmodule

`default_nettype wire

/* src/dynamics.sv */
// amplitude clipper followed by a 2:1 compressor above a pot-set threshold, per channel
`default_nettype none
`include "daf_consts.svh"

module dynamics (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic              dyn_step,
  input  logic              clip_en,
  input  logic              comp_en,
  input  logic [3:0]        pot_amp_clp,
  input  logic [3:0]        pot_amp_com,
  input  daf_pkg::stereo_t  comb_out,
  output daf_pkg::stereo_t  dyn_out
);
  import daf_pkg::*;

  // clip then compress one channel, either step can be skipped
  function automatic sample_t shape(sample_t x, logic do_clip, logic do_comp,
                                    logic [3:0] clp_pot, logic [3:0] com_pot);
    int v;
    int clip_th;
    int comp_th;
    v       = int'(x);
    clip_th = (int'(clp_pot) + 1) * `DAF_POT_STEP - 1;
    comp_th = (int'(com_pot) + 1) * `DAF_POT_STEP;
    if (do_clip) begin
      if (v > clip_th) begin
        v = clip_th;
      end else if (v < -clip_th) begin
        v = -clip_th;
      end
    end
    // halve the excess beyond the threshold, floored
    if (do_comp) begin
      if (v > comp_th) begin
        v = comp_th + ((v - comp_th) >>> 1);
      end else if (v < -comp_th) begin
        v = -comp_th + ((v + comp_th) >>> 1);
      end
    end
    return sample_t'(v);
  endfunction

  stereo_t shaped;

  assign shaped.left  = shape(comb_out.left, clip_en, comp_en, pot_amp_clp, pot_amp_com);
  assign shaped.right = shape(comb_out.right, clip_en, comp_en, pot_amp_clp, pot_amp_com);

  // with both enables low the function hands the sample back untouched
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      dyn_out <= '0;
    end else if (dyn_step) begin
      dyn_out <= shaped;
    end
  end

endmodule

`default_nettype wire

/* src/gain_stage.sv */
// fader ramp and volume control, scales both channels by pot volume and the fade gain
`default_nettype none
`include "daf_consts.svh"

module gain_stage (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic              gain_step,
  input  logic              fade_en,
  input  logic [3:0]        pot_vol,
  input  daf_pkg::stereo_t  dyn_out,
  output daf_pkg::stereo_t  gain_out
);
  import daf_pkg::*;

  localparam int GAIN_W      = $clog2(`DAF_FADE_UNITY + 1);
  // full volume times unity fade is the divisor
  localparam int SCALE_SHIFT = $clog2(16 * `DAF_FADE_UNITY);

  logic [GAIN_W-1:0] fade_gain;
  logic [GAIN_W-1:0] gain_used;

  function automatic sample_t scale(sample_t x, logic [3:0] vol, logic [GAIN_W-1:0] g);
    int prod;
    prod = int'(x) * (int'(vol) + 1) * int'(g);
    return sample_t'(prod >>> SCALE_SHIFT);
  endfunction

  // fade off means unity right away, else the gain from before this step
  assign gain_used = fade_en ? fade_gain : GAIN_W'(`DAF_FADE_UNITY);

  // ramp down one count per frame while fading, hold at zero
  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      fade_gain <= GAIN_W'(`DAF_FADE_UNITY);
    end else if (gain_step) begin
      if (!fade_en) begin
        fade_gain <= GAIN_W'(`DAF_FADE_UNITY);
      end else if (fade_gain != '0) begin
        fade_gain <= fade_gain - 1'b1;
      end
    end
  end

  always_ff @(posedge tb_clk) begin
    if (!rst_n) begin
      gain_out <= '0;
    end else if (gain_step) begin
      gain_out.left  <= scale(dyn_out.left, pot_vol, gain_used);
      gain_out.right <= scale(dyn_out.right, pot_vol, gain_used);
    end
  end

endmodule

`default_nettype wire

/* src/daf.sv */
// top level of the stereo effects processor, wiring the frame sequencer to the three effect stages
`default_nettype none

module daf (
  input  logic              tb_clk,
  input  logic              rst_n,
  input  logic [3:0]        pot_vol,
  input  logic [3:0]        pot_amp_clp,
  input  logic [3:0]        pot_amp_com,
  input  logic [3:0]        swch_mode_en,
  input  logic              mem_clr,
  input  daf_pkg::stereo_t  temp_in,
  output daf_pkg::stereo_t  temp_out,
  output logic              sample_strobe
);
  import daf_pkg::*;

  mode_t   mode;
  stereo_t in_sample;
  stereo_t comb_out;
  stereo_t dyn_out;
  stereo_t gain_out;
  logic    comb_step;
  logic    dyn_step;
  logic    gain_step;

  effect_ctrl ctrl_i (
    .tb_clk        (tb_clk),
    .rst_n         (rst_n),
    .swch_mode_en  (swch_mode_en),
    .temp_in       (temp_in),
    .gain_out      (gain_out),
    .mode          (mode),
    .in_sample     (in_sample),
    .comb_step     (comb_step),
    .dyn_step      (dyn_step),
    .gain_step     (gain_step),
    .sample_strobe (sample_strobe),
    .temp_out      (temp_out)
  );

  comb_filter comb_i (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .comb_step (comb_step),
    .mem_clr   (mem_clr),
    .enable    (mode.comb),
    .in_sample (in_sample),
    .comb_out  (comb_out)
  );

  dynamics dyn_i (
    .tb_clk      (tb_clk),
    .rst_n       (rst_n),
    .dyn_step    (dyn_step),
    .clip_en     (mode.clip),
    .comp_en     (mode.comp),
    .pot_amp_clp (pot_amp_clp),
    .pot_amp_com (pot_amp_com),
    .comb_out    (comb_out),
    .dyn_out     (dyn_out)
  );

  gain_stage gain_i (
    .tb_clk    (tb_clk),
    .rst_n     (rst_n),
    .gain_step (gain_step),
    .fade_en   (mode.fade),
    .pot_vol   (pot_vol),
    .dyn_out   (dyn_out),
    .gain_out  (gain_out)
  );

endmodule

`default_nettype wire

/* test/tb_daf.sv */
// directed testbench for daf that streams stereo frames and checks each result against a frame model
`default_nettype none
`include "daf_consts.svh"

module tb_daf;
  import daf_pkg::*;

  // about 92 frames of tests plus reset and some margin
  localparam int MAX_CYCLES = 4000;

  logic       tb_clk;
  logic       rst_n;
  logic [3:0] pot_vol;
  logic [3:0] pot_amp_clp;
  logic [3:0] pot_amp_com;
  logic [3:0] swch_mode_en;
  logic       mem_clr;
  stereo_t    temp_in;
  stereo_t    temp_out;
  logic       sample_strobe;

  integer  seed;
  int      cycles;
  int      errors;
  int      checks;
  int      tests;
  int      last_strobe;
  logic    have_prev;
  stereo_t exp_prev;

  // settings applied together with the next sample
  logic [3:0] cfg_mode;
  logic [3:0] cfg_vol;
  logic [3:0] cfg_clp;
  logic [3:0] cfg_com;

  // model state for comb history and fade gain
  stereo_t hist [`DAF_COMB_DELAY];
  int      hist_ptr;
  int      fade_g;

  daf dut_i (
    .tb_clk        (tb_clk),
    .rst_n         (rst_n),
    .pot_vol       (pot_vol),
    .pot_amp_clp   (pot_amp_clp),
    .pot_amp_com   (pot_amp_com),
    .swch_mode_en  (swch_mode_en),
    .mem_clr       (mem_clr),
    .temp_in       (temp_in),
    .temp_out      (temp_out),
    .sample_strobe (sample_strobe)
  );

  always #2 tb_clk = ~tb_clk;

  always @(posedge tb_clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic int floor_div(int n, int d);
    int q;
    q = n / d;
    if ((n % d != 0) && (n < 0)) begin
      q = q - 1;
    end
    return q;
  endfunction

  // clip to +-tc and then halve the excess over +-tm
  function automatic int shape_ref(int x, logic clip, logic comp, int clp_pot, int com_pot);
    int tc;
    int tm;
    int v;
    tc = (clp_pot + 1) * `DAF_POT_STEP - 1;
    tm = (com_pot + 1) * `DAF_POT_STEP;
    v  = x;
    if (clip && v > tc) begin
      v = tc;
    end else if (clip && v < -tc) begin
      v = -tc;
    end
    if (comp && v > tm) begin
      v = tm + floor_div(v - tm, 2);
    end else if (comp && v < -tm) begin
      v = -tm + floor_div(v + tm, 2);
    end
    return v;
  endfunction

  function automatic int channel_ref(int x, int d, mode_t m, int vol, int g);
    int v;
    v = m.comb ? floor_div(x + d, 2) : x;
    v = shape_ref(v, m.clip, m.comp, int'(cfg_clp), int'(cfg_com));
    return floor_div(v * (vol + 1) * g, 16 * `DAF_FADE_UNITY);
  endfunction

  task automatic model_frame(input stereo_t x, output stereo_t y);
    stereo_t d;
    mode_t   m;
    int      g;
    m = mode_t'(cfg_mode);
    d = hist[hist_ptr];
    hist[hist_ptr] = x;
    hist_ptr = (hist_ptr + 1) % `DAF_COMB_DELAY;
    if (m.fade) begin
      g = fade_g;
      if (fade_g > 0) begin
        fade_g = fade_g - 1;
      end
    end else begin
      g = `DAF_FADE_UNITY;
      fade_g = `DAF_FADE_UNITY;
    end
    y.left  = sample_t'(channel_ref(int'(x.left), int'(d.left), m, int'(cfg_vol), g));
    y.right = sample_t'(channel_ref(int'(x.right), int'(d.right), m, int'(cfg_vol), g));
  endtask

  task automatic clear_history();
    for (int i = 0; i < `DAF_COMB_DELAY; i++) begin
      hist[i] = '0;
    end
    hist_ptr = 0;
  endtask

  // drive one sample at the strobe and read back the previous sample's result
  task automatic run_frame(input stereo_t x);
    stereo_t exp_now;
    do begin
      @(posedge tb_clk);
      #1;
    end while (!sample_strobe);
    if (last_strobe >= 0) begin
      assert (cycles - last_strobe == `DAF_SAMPLE_CYCLES) else begin
        $display("[ERROR] sample_strobe period expected %h got %h",
                 `DAF_SAMPLE_CYCLES, cycles - last_strobe);
        errors++;
      end
    end
    last_strobe  = cycles;
    temp_in      = x;
    swch_mode_en = cfg_mode;
    pot_vol      = cfg_vol;
    pot_amp_clp  = cfg_clp;
    pot_amp_com  = cfg_com;
    model_frame(x, exp_now);
    @(posedge tb_clk);
    #1;
    if (have_prev) begin
      checks++;
      assert (temp_out == exp_prev) else begin
        $display("[ERROR] temp_out expected %h got %h", exp_prev, temp_out);
        errors++;
      end
    end
    exp_prev  = exp_now;
    have_prev = 1'b1;
  endtask

  // clear lands after the comb step of the sample just driven
  task automatic pulse_mem_clr();
    @(posedge tb_clk);
    #1;
    mem_clr = 1'b1;
    @(posedge tb_clk);
    #1;
    mem_clr = 1'b0;
    clear_history();
  endtask

  task automatic report_test(input string name, input int start_errors);
    tests++;
    $display("%s: %0d errors", name, errors - start_errors);
  endtask

  task automatic test_passthrough();
    int start;
    start    = errors;
    cfg_mode = 4'b0000;
    cfg_vol  = 4'd15;
    repeat (8) run_frame(stereo_t'($random(seed)));
    run_frame('0);
    report_test("passthrough", start);
  endtask

  task automatic test_volume();
    int start;
    start    = errors;
    cfg_mode = 4'b0000;
    for (int k = 0; k < 3; k++) begin
      cfg_vol = (k == 0) ? 4'd0 : (k == 1) ? 4'd7 : 4'd15;
      repeat (3) run_frame(stereo_t'($random(seed)));
    end
    run_frame('0);
    report_test("volume", start);
  endtask

  task automatic test_comb();
    int start;
    start    = errors;
    cfg_mode = 4'b0001;
    cfg_vol  = 4'd15;
    pulse_mem_clr();
    run_frame({16'sd12000, -16'sd9000});
    // echo shows up on the eighth zero frame
    repeat (10) run_frame('0);
    report_test("comb", start);
  endtask

  task automatic test_dynamics();
    int start;
    start   = errors;
    cfg_vol = 4'd15;
    for (int p = 0; p < 2; p++) begin
      cfg_clp = (p == 0) ? 4'd3 : 4'd9;
      cfg_com = (p == 0) ? 4'd1 : 4'd5;
      // clip alone, compress alone, then both
      for (int k = 0; k < 3; k++) begin
        cfg_mode = 4'((k + 1) << 1);
        repeat (4) run_frame(stereo_t'($random(seed)));
      end
    end
    run_frame('0);
    report_test("dynamics", start);
  endtask

  task automatic test_fader();
    int      start;
    stereo_t x;
    start    = errors;
    x        = {16'sh4000, -16'sd12345};
    cfg_mode = 4'b1000;
    cfg_vol  = 4'd15;
    repeat (18) run_frame(x);
    cfg_mode = 4'b0000;
    repeat (3) run_frame(x);
    report_test("fader", start);
  endtask

  task automatic test_mem_clear();
    int start;
    start    = errors;
    cfg_mode = 4'b0001;
    cfg_vol  = 4'd15;
    repeat (6) run_frame(stereo_t'($random(seed)));
    pulse_mem_clr();
    repeat (9) run_frame(stereo_t'($random(seed)));
    run_frame('0);
    report_test("mem_clear", start);
  endtask

  initial begin
    seed         = 32'hee9f;
    tb_clk       = 1'b0;
    rst_n        = 1'b0;
    pot_vol      = 4'd0;
    pot_amp_clp  = 4'd0;
    pot_amp_com  = 4'd0;
    swch_mode_en = 4'd0;
    mem_clr      = 1'b0;
    temp_in      = '0;
    cycles       = 0;
    errors       = 0;
    checks       = 0;
    tests        = 0;
    last_strobe  = -1;
    have_prev    = 1'b0;
    exp_prev     = '0;
    cfg_mode     = 4'd0;
    cfg_vol      = 4'd15;
    cfg_clp      = 4'd15;
    cfg_com      = 4'd15;
    fade_g       = `DAF_FADE_UNITY;
    clear_history();
    repeat (4) @(posedge tb_clk);
    #1;
    rst_n = 1'b1;
    test_passthrough();
    test_volume();
    test_comb();
    test_dynamics();
    test_fader();
    test_mem_clear();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* daf.f */
+incdir+src
src/daf_pkg.sv
src/effect_ctrl.sv
src/comb_filter.sv
src/dynamics.sv
src/gain_stage.sv
src/daf.sv
test/tb_daf.sv

/* run_sim.sh */
#!/bin/sh
# build the daf testbench with Verilator, run it, and scan the log for failure

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

if ! verilator --binary --timing -Wno-fatal -f daf.f --top-module tb_daf \
    -Mdir "$OBJ" -o tb_daf; then
  echo "build failed"
  exit 1
fi

if ! "./$OBJ/tb_daf" > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "TEST OK" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi

exit 0
